// ==== verilog/cam_pkg.sv ====
// key and entry index types for the associative table, imported by every cam block
`default_nettype none

package cam_pkg;

	// stored key geometry
	localparam int KEY_W = 16;	// bits per key
	localparam int DEPTH = 32;	// number of entries

	// index width derived from depth
	localparam int INDEX_W = $clog2(DEPTH);

	// a key, or a per-bit mask over a key
	typedef logic [KEY_W-1:0] key_t;

	typedef logic [INDEX_W-1:0] index_t;	// entry number

	// one bit per entry, bit i for entry i
	typedef logic [DEPTH-1:0] match_vec_t;

endpackage

`default_nettype wire

// ==== verilog/table_pkg.sv ====
// payload word type stored next to each table entry, used by the payload stage and the top
`default_nettype none

package table_pkg;

	// width of the data word kept per entry
	localparam int PAYLOAD_W = 12;

	// e.g. a physical page number or a queue slot tag
	typedef logic [PAYLOAD_W-1:0] payload_t;

endpackage

`default_nettype wire

// ==== verilog/cam_if.sv ====
// write-port and search-port bundles passed between the top level, the key array and payload stage
`timescale 1ns/1ps
`default_nettype none

// all write ports side by side, index p is port p
interface cam_write_if import cam_pkg::*, table_pkg::*; #(
	parameter int WRITE_PORTS = 2
)();

	logic     [WRITE_PORTS-1:0] en;		// one-cycle write strobe
	key_t     [WRITE_PORTS-1:0] mask;		// 1 keeps old bit
	key_t     [WRITE_PORTS-1:0] key;		// new key bits
	index_t   [WRITE_PORTS-1:0] index;		// target entry
	logic     [WRITE_PORTS-1:0] payload_en;	// also replace payload
	payload_t [WRITE_PORTS-1:0] payload;

	// driven from the top level pins
	modport src (
		output en, mask, key, index, payload_en, payload
	);

	// key array and payload store both consume it
	modport dst (
		input en, mask, key, index, payload_en, payload
	);

endinterface

// all search ports, request half plus combinational result half
interface cam_search_if import cam_pkg::*; #(
	parameter int SEARCH_PORTS = 3
)();

	logic   [SEARCH_PORTS-1:0] en;		// one-cycle search strobe
	key_t   [SEARCH_PORTS-1:0] mask;	// 1 is don't care
	key_t   [SEARCH_PORTS-1:0] key;
	logic   [SEARCH_PORTS-1:0] hit;		// any entry matched
	logic   [SEARCH_PORTS-1:0] multi;	// two or more matched
	index_t [SEARCH_PORTS-1:0] index;	// preferred matching entry

	modport req (output en, mask, key);

	// array answers within the cycle
	modport rsp (
		input  en, mask, key,
		output hit, multi, index
	);

	modport mon (input en, mask, key, hit, multi, index);	// payload stage watches all

endinterface

`default_nettype wire

// ==== verilog/hit_selector.sv ====
// priority encoder over the per-entry match bits, lowest or highest set bit by parameter
`timescale 1ns/1ps
`default_nettype none

module hit_selector import cam_pkg::*; #(
	parameter int PICK_MSB = 0	// 1 prefers highest index
)(
	input  wire match_vec_t sel,
	output logic            valid,
	output index_t          index
);

	// any set bit at all
	assign valid = |sel;

	always_comb begin
		index = '0;	// stays 0 when nothing set
		if (PICK_MSB != 0) begin
			// upward scan, last set bit seen wins
			for (int i = 0; i < DEPTH; i++) begin
				if (sel[i]) begin
					index = index_t'(i);
				end
			end
		end else begin
			// downward scan so the lowest set bit is the one left
			for (int i = DEPTH - 1; i >= 0; i--) begin
				if (sel[i]) begin
					index = index_t'(i);
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/cam_sel.sv ====
// reduces one search port's match vector into hit, multi-hit flag and preferred index
`timescale 1ns/1ps
`default_nettype none

module cam_sel import cam_pkg::*; #(
	parameter int PICK_MSB = 0
)(
	input  wire match_vec_t sel,	// one bit per entry
	output logic            hit,
	output logic            multi,	// more than one entry matched
	output index_t          index
);

	logic seen;	// a match already passed in the scan

	// running flag across the vector, second match sets multi
	always_comb begin
		seen  = 1'b0;
		multi = 1'b0;
		for (int i = 0; i < DEPTH; i++) begin
			if (sel[i] && seen) begin
				multi = 1'b1;
			end
			seen = seen | sel[i];
		end
	end

	// hit and index straight from the encoder
	hit_selector #(
		.PICK_MSB (PICK_MSB)
	) u_pick (
		.sel   (sel),
		.valid (hit),
		.index (index)
	);

endmodule

`default_nettype wire

// ==== verilog/cam_array.sv ====
// masked key storage with multi-port masked write and parallel masked compare per search port
`timescale 1ns/1ps
`default_nettype none

module cam_array import cam_pkg::*; #(
	parameter int WRITE_PORTS  = 2,
	parameter int SEARCH_PORTS = 3,
	parameter int PICK_MSB     = 0
)(
	input wire        clk,
	input wire        arst_n,
	cam_write_if.dst  wr,
	cam_search_if.rsp srch
);

	key_t cells      [DEPTH];	// stored keys
	key_t next_cells [DEPTH];	// contents after this cycle's writes

	// write merge
	// ports applied low to high, so per bit the highest writing port wins
	always_comb begin
		next_cells = cells;
		for (int p = 0; p < WRITE_PORTS; p++) begin
			if (wr.en[p]) begin
				next_cells[wr.index[p]] = (next_cells[wr.index[p]] & wr.mask[p])
					| (wr.key[p] & ~wr.mask[p]);	// unmasked bits take new key
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int e = 0; e < DEPTH; e++) begin
				cells[e] <= '0;
			end
		end else begin
			cells <= next_cells;
		end
	end

	// compare side, reads cells before the edge so writes show a cycle later
	for (genvar s = 0; s < SEARCH_PORTS; s++) begin : g_srch
		match_vec_t match;	// entries equal under the don't care mask

		always_comb begin
			for (int e = 0; e < DEPTH; e++) begin
				// each bit masked out or equal, idle port matches nothing
				match[e] = srch.en[s]
					&& (&(srch.mask[s] | ~(cells[e] ^ srch.key[s])));
			end
		end

		cam_sel #(
			.PICK_MSB (PICK_MSB)
		) u_sel (
			.sel   (match),
			.hit   (srch.hit[s]),
			.multi (srch.multi[s]),
			.index (srch.index[s])
		);
	end

endmodule

`default_nettype wire

// ==== verilog/payload_ram.sv ====
// per-entry payload store and the registered one-cycle response stage for all search ports
`timescale 1ns/1ps
`default_nettype none

module payload_ram import cam_pkg::*, table_pkg::*; #(
	parameter int WRITE_PORTS  = 2,
	parameter int SEARCH_PORTS = 3
)(
	input  wire                         clk,
	input  wire                         arst_n,
	cam_write_if.dst                    wr,
	cam_search_if.mon                   srch,
	output logic     [SEARCH_PORTS-1:0] rsp_valid,	// one cycle after srch en
	output logic     [SEARCH_PORTS-1:0] rsp_hit,
	output logic     [SEARCH_PORTS-1:0] rsp_multi,
	output index_t   [SEARCH_PORTS-1:0] rsp_index,
	output payload_t [SEARCH_PORTS-1:0] rsp_payload
);

	payload_t mem [DEPTH];	// one word per entry

	// payload write, whole word
	// later nonblocking assignment wins so the highest port takes a shared entry
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int e = 0; e < DEPTH; e++) begin
				mem[e] <= '0;
			end
		end else begin
			for (int p = 0; p < WRITE_PORTS; p++) begin
				if (wr.en[p] && wr.payload_en[p]) begin
					mem[wr.index[p]] <= wr.payload[p];
				end
			end
		end
	end

	// response register
	// idle ports load zeros, so outputs read 0 whenever valid is low
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rsp_valid   <= '0;
			rsp_hit     <= '0;
			rsp_multi   <= '0;
			rsp_index   <= '0;
			rsp_payload <= '0;
		end else begin
			for (int s = 0; s < SEARCH_PORTS; s++) begin
				rsp_valid[s] <= srch.en[s];
				rsp_hit[s]   <= srch.hit[s];	// already 0 on an idle port
				rsp_multi[s] <= srch.multi[s];
				rsp_index[s] <= srch.index[s];	// 0 on miss from the encoder
				// old word, the same-edge write lands after this read
				rsp_payload[s] <= srch.hit[s] ? mem[srch.index[s]] : '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/lookup_table.sv ====
// top level of the associative lookup table, plain port arrays in and registered responses out
`timescale 1ns/1ps
`default_nettype none

module lookup_table import cam_pkg::*, table_pkg::*; #(
	parameter int WRITE_PORTS  = 2,
	parameter int SEARCH_PORTS = 3,
	parameter int PICK_MSB     = 0	// 0 lowest index, 1 highest
)(
	input  wire                           clk,
	input  wire                           arst_n,

	// write ports
	input  wire      [WRITE_PORTS-1:0]    wr_en,
	input  wire key_t     [WRITE_PORTS-1:0] wr_mask,	// 1 keeps bit
	input  wire key_t     [WRITE_PORTS-1:0] wr_key,
	input  wire index_t   [WRITE_PORTS-1:0] wr_index,
	input  wire      [WRITE_PORTS-1:0]    wr_payload_en,
	input  wire payload_t [WRITE_PORTS-1:0] wr_payload,

	// search ports
	input  wire      [SEARCH_PORTS-1:0]   srch_en,
	input  wire key_t [SEARCH_PORTS-1:0]  srch_mask,	// 1 is don't care
	input  wire key_t [SEARCH_PORTS-1:0]  srch_key,

	// responses, one cycle after srch_en
	output logic     [SEARCH_PORTS-1:0]   rsp_valid,
	output logic     [SEARCH_PORTS-1:0]   rsp_hit,
	output logic     [SEARCH_PORTS-1:0]   rsp_multi,
	output index_t   [SEARCH_PORTS-1:0]   rsp_index,
	output payload_t [SEARCH_PORTS-1:0]   rsp_payload
);

	cam_write_if  #(.WRITE_PORTS (WRITE_PORTS))  wr_if ();
	cam_search_if #(.SEARCH_PORTS(SEARCH_PORTS)) srch_if ();

	// pins onto the write bundle
	assign wr_if.en         = wr_en;
	assign wr_if.mask       = wr_mask;
	assign wr_if.key        = wr_key;
	assign wr_if.index      = wr_index;
	assign wr_if.payload_en = wr_payload_en;
	assign wr_if.payload    = wr_payload;

	// request half of the search bundle
	assign srch_if.en   = srch_en;
	assign srch_if.mask = srch_mask;
	assign srch_if.key  = srch_key;

	cam_array #(
		.WRITE_PORTS  (WRITE_PORTS),
		.SEARCH_PORTS (SEARCH_PORTS),
		.PICK_MSB     (PICK_MSB)
	) u_array (
		.clk    (clk),
		.arst_n (arst_n),
		.wr     (wr_if.dst),
		.srch   (srch_if.rsp)	// fills hit, multi, index
	);

	payload_ram #(
		.WRITE_PORTS  (WRITE_PORTS),
		.SEARCH_PORTS (SEARCH_PORTS)
	) u_payload (
		.clk         (clk),
		.arst_n      (arst_n),
		.wr          (wr_if.dst),
		.srch        (srch_if.mon),
		.rsp_valid   (rsp_valid),
		.rsp_hit     (rsp_hit),
		.rsp_multi   (rsp_multi),
		.rsp_index   (rsp_index),
		.rsp_payload (rsp_payload)
	);

endmodule

`default_nettype wire

// ==== sim/tb_lookup_table.sv ====
// self-checking testbench for lookup_table that run.sh builds and runs against a shadow model
`timescale 1ns/1ps
`default_nettype none

module tb_lookup_table import cam_pkg::*, table_pkg::*; ();

	localparam int WP       = 2;	// DUT default write ports
	localparam int SP       = 3;	// DUT default search ports
	localparam int N_RANDOM = 2000;

	// expected response of one search port
	typedef struct packed {
		logic     valid;
		logic     hit;
		logic     multi;
		index_t   index;
		payload_t payload;
	} expect_t;

	logic clk = 1'b0;
	logic arst_n;
	logic     [WP-1:0] wr_en;
	key_t     [WP-1:0] wr_mask;
	key_t     [WP-1:0] wr_key;
	index_t   [WP-1:0] wr_index;
	logic     [WP-1:0] wr_payload_en;
	payload_t [WP-1:0] wr_payload;
	logic     [SP-1:0] srch_en;
	key_t     [SP-1:0] srch_mask;
	key_t     [SP-1:0] srch_key;
	logic     [SP-1:0] rsp_valid;
	logic     [SP-1:0] rsp_hit;
	logic     [SP-1:0] rsp_multi;
	index_t   [SP-1:0] rsp_index;
	payload_t [SP-1:0] rsp_payload;

	// staged stimulus that drive_cycle moves onto the pins
	logic     [WP-1:0] st_wr_en;
	key_t     [WP-1:0] st_wr_mask;
	key_t     [WP-1:0] st_wr_key;
	index_t   [WP-1:0] st_wr_index;
	logic     [WP-1:0] st_wr_payload_en;
	payload_t [WP-1:0] st_wr_payload;
	logic     [SP-1:0] st_srch_en;
	key_t     [SP-1:0] st_srch_mask;
	key_t     [SP-1:0] st_srch_key;

	key_t        shadow_key [DEPTH];	// model of the key cells
	payload_t    shadow_pay [DEPTH];
	expect_t     pend_exp   [SP];	// for the searches on the pins now
	expect_t     chk_exp    [SP];	// due on the outputs this cycle
	logic [31:0] rng_state;
	string       test_name;
	string       pend_name;	// test that put the current searches on the pins
	string       chk_name;	// test whose responses are due now
	int          n_strobes;		// search strobes sent
	int          n_checked;		// responses compared

	lookup_table uut (
		.clk           (clk),
		.arst_n        (arst_n),
		.wr_en         (wr_en),
		.wr_mask       (wr_mask),
		.wr_key        (wr_key),
		.wr_index      (wr_index),
		.wr_payload_en (wr_payload_en),
		.wr_payload    (wr_payload),
		.srch_en       (srch_en),
		.srch_mask     (srch_mask),
		.srch_key      (srch_key),
		.rsp_valid     (rsp_valid),
		.rsp_hit       (rsp_hit),
		.rsp_multi     (rsp_multi),
		.rsp_index     (rsp_index),
		.rsp_payload   (rsp_payload)
	);

	always #4 clk = ~clk;	// 8 ns period

	// 32-bit LCG returning the upper half since the low bits cycle short
	function automatic logic [15:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state[31:16];
	endfunction

	function automatic key_t fill_key(int e);
		return key_t'(32'hA005 + (e << 4));	// distinct per entry and never 0
	endfunction

	// a bit matches when masked out or equal and the lowest matching entry wins
	function automatic expect_t ref_search(key_t key, key_t mask);
		expect_t r;
		int      count;
		r       = '0;
		r.valid = 1'b1;
		count   = 0;
		for (int e = 0; e < DEPTH; e++) begin
			if (((shadow_key[e] ^ key) & ~mask) == '0) begin
				if (count == 0) begin
					r.index   = index_t'(e);
					r.payload = shadow_pay[e];
				end
				count++;
			end
		end
		r.hit   = (count > 0);
		r.multi = (count > 1);
		return r;
	endfunction

	task automatic stop_run();
		$display("Test failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_flag(string what, int port, logic exp, logic act);
		if (act !== exp) begin
			$display("Error %s port %0d %s expected %0b actual %0b",
				chk_name, port, what, exp, act);
			stop_run();
		end
	endtask

	task automatic check_index(string what, int port, index_t exp, index_t act);
		if (act !== exp) begin
			$display("Error %s port %0d %s expected %0d actual %0d",
				chk_name, port, what, exp, act);
			stop_run();
		end
	endtask

	task automatic check_payload(string what, int port, payload_t exp, payload_t act);
		if (act !== exp) begin
			$display("Error %s port %0d %s expected %h actual %h",
				chk_name, port, what, exp, act);
			stop_run();
		end
	endtask

	// ports in ascending order so a later port overwrites per bit
	task automatic commit_writes();
		index_t idx;
		for (int p = 0; p < WP; p++) begin
			idx = st_wr_index[p];
			if (st_wr_en[p]) begin
				for (int b = 0; b < KEY_W; b++) begin
					if (!st_wr_mask[p][b]) begin
						shadow_key[idx][b] = st_wr_key[p][b];	// mask 0 takes new bit
					end
				end
				if (st_wr_payload_en[p]) begin
					shadow_pay[idx] = st_wr_payload[p];
				end
			end
		end
	endtask

	task automatic clear_stim();
		st_wr_en         = '0;
		st_wr_mask       = '0;
		st_wr_key        = '0;
		st_wr_index      = '0;
		st_wr_payload_en = '0;
		st_wr_payload    = '0;
		st_srch_en       = '0;
		st_srch_mask     = '0;
		st_srch_key      = '0;
	endtask

	task automatic set_write(int p, int idx, key_t key, key_t mask, logic pen, payload_t pay);
		st_wr_en[p]         = 1'b1;
		st_wr_index[p]      = index_t'(idx);
		st_wr_key[p]        = key;
		st_wr_mask[p]       = mask;
		st_wr_payload_en[p] = pen;
		st_wr_payload[p]    = pay;
	endtask

	task automatic set_search(int s, key_t key, key_t mask);
		st_srch_en[s]   = 1'b1;
		st_srch_key[s]  = key;
		st_srch_mask[s] = mask;
	endtask

	// one clock of stimulus whose expected values use the contents before this cycle's writes
	task automatic drive_cycle();
		@(posedge clk);
		for (int s = 0; s < SP; s++) begin
			if (st_srch_en[s]) begin
				pend_exp[s] <= ref_search(st_srch_key[s], st_srch_mask[s]);
				n_strobes++;
			end else begin
				pend_exp[s] <= '0;
			end
		end
		pend_name     <= test_name;
		wr_en         <= st_wr_en;
		wr_mask       <= st_wr_mask;
		wr_key        <= st_wr_key;
		wr_index      <= st_wr_index;
		wr_payload_en <= st_wr_payload_en;
		wr_payload    <= st_wr_payload;
		srch_en       <= st_srch_en;
		srch_mask     <= st_srch_mask;
		srch_key      <= st_srch_key;
		commit_writes();
	endtask

	task automatic random_stim();
		logic [15:0] r;
		for (int p = 0; p < WP; p++) begin
			r = next_rand();
			st_wr_en[p]         = r[15];
			st_wr_payload_en[p] = r[14];
			st_wr_index[p]      = index_t'(r);
			st_wr_key[p]        = 16'hC000 | (next_rand() & 16'h003F);	// small key space
			r = next_rand();
			st_wr_mask[p]       = (r[15:14] == 2'b00) ? next_rand() : '0;
			st_wr_payload[p]    = payload_t'(next_rand());
		end
		for (int s = 0; s < SP; s++) begin
			r = next_rand();
			st_srch_en[s]   = r[15] | r[14];	// busy about 3 cycles in 4
			st_srch_key[s]  = 16'hC000 | (next_rand() & 16'h003F);
			st_srch_mask[s] = (r[13:12] == 2'b00) ? (next_rand() & 16'h0033) : '0;
		end
	endtask

	// one-cycle delay line from the pins to the response
	always @(posedge clk) begin
		for (int s = 0; s < SP; s++) begin
			chk_exp[s] <= pend_exp[s];
		end
		chk_name <= pend_name;
	end

	// compare at the falling edge where outputs have settled
	always @(negedge clk) begin
		for (int s = 0; s < SP; s++) begin
			if (chk_exp[s].valid) begin
				if (rsp_valid[s] !== 1'b1) begin
					$display("no response on port %0d one cycle after a search in %s", s, chk_name);
					stop_run();
				end
				check_flag("hit", s, chk_exp[s].hit, rsp_hit[s]);
				check_flag("multi", s, chk_exp[s].multi, rsp_multi[s]);
				check_index("index", s, chk_exp[s].index, rsp_index[s]);
				check_payload("payload", s, chk_exp[s].payload, rsp_payload[s]);
				n_checked++;
			end else begin
				if (rsp_valid[s] !== 1'b0) begin
					$display("response on port %0d without a search strobe in %s", s, chk_name);
					stop_run();
				end
				check_flag("idle hit", s, 1'b0, rsp_hit[s]);	// outputs 0 while not valid
				check_flag("idle multi", s, 1'b0, rsp_multi[s]);
				check_index("idle index", s, '0, rsp_index[s]);
				check_payload("idle payload", s, '0, rsp_payload[s]);
			end
		end
	end

	initial begin
		int wait_cnt;
		rng_state = 32'd4604;
		n_strobes = 0;
		n_checked = 0;
		test_name = "reset";
		pend_name = "reset";
		chk_name  = "reset";
		clear_stim();
		for (int e = 0; e < DEPTH; e++) begin
			shadow_key[e] = '0;
			shadow_pay[e] = '0;
		end
		for (int s = 0; s < SP; s++) begin
			pend_exp[s] = '0;
			chk_exp[s]  = '0;
		end
		arst_n        = 1'b0;
		wr_en         = '0;
		wr_mask       = '0;
		wr_key        = '0;
		wr_index      = '0;
		wr_payload_en = '0;
		wr_payload    = '0;
		srch_en       = '0;
		srch_mask     = '0;
		srch_key      = '0;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;

		// quiet cycles after reset then key 0 hits every zeroed entry
		for (int i = 0; i < 3; i++) drive_cycle();
		set_search(0, '0, '0);
		drive_cycle();

		test_name = "fill";
		for (int e = 0; e < DEPTH; e += WP) begin
			clear_stim();
			for (int p = 0; p < WP; p++) begin
				set_write(p, e + p, fill_key(e + p), '0, 1'b1,
					payload_t'(32'h800 ^ ((e + p) * 37)));
			end
			drive_cycle();
		end
		test_name = "exact search";
		for (int e = 0; e < DEPTH; e += SP) begin
			clear_stim();
			for (int s = 0; s < SP; s++) begin
				if (e + s < DEPTH) set_search(s, fill_key(e + s), '0);
			end
			drive_cycle();
		end

		test_name = "masked write";
		clear_stim();
		set_write(0, 5, 16'h3C3C, 16'hFF00, 1'b0, '0);	// entry 5 becomes A03C
		drive_cycle();
		clear_stim();
		set_search(0, 16'hA03C, '0);
		set_search(1, fill_key(5), '0);	// old key now misses
		drive_cycle();

		test_name = "dont care";
		clear_stim();
		set_search(0, 16'hA005, 16'h01F0);
		set_search(1, 16'hA005, 16'h0070);
		set_search(2, 16'hA085, 16'h0030);	// entries 8 to 11
		drive_cycle();

		test_name = "same cycle";
		clear_stim();
		set_write(0, 10, 16'h7777, '0, 1'b1, 12'h123);
		set_search(0, fill_key(10), '0);	// still old contents
		set_search(1, 16'h7777, '0);
		drive_cycle();
		clear_stim();
		set_search(0, 16'h7777, '0);
		drive_cycle();

		test_name = "collision";
		clear_stim();
		set_write(0, 12, 16'h1111, '0, 1'b1, 12'hAAA);
		set_write(1, 12, 16'h2222, 16'hF0F0, 1'b1, 12'h555);	// upper port wins
		drive_cycle();
		clear_stim();
		set_search(0, 16'h1212, '0);
		set_search(1, 16'h1111, '0);
		set_search(2, 16'h2222, '0);
		drive_cycle();

		test_name = "random";
		for (int c = 0; c < N_RANDOM; c++) begin
			random_stim();
			drive_cycle();
		end

		// drain the response stage within a bounded number of cycles
		test_name = "drain";
		clear_stim();
		wait_cnt = 0;
		while (n_checked != n_strobes && wait_cnt < 8) begin
			drive_cycle();
			wait_cnt++;
		end
		drive_cycle();

		if (n_checked == n_strobes) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("responses missing, %0d strobes sent and %0d compared",
				n_strobes, n_checked);
			stop_run();
		end
	end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/cam_pkg.sv
verilog/table_pkg.sv
verilog/cam_if.sv
verilog/hit_selector.sv
verilog/cam_sel.sv
verilog/cam_array.sv
verilog/payload_ram.sv
verilog/lookup_table.sv
sim/tb_lookup_table.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and pass only if the pass message shows up.
cd "$(dirname "$0")" || exit 1

verilator --binary -f project.f --top-module tb_lookup_table -o tb_lookup_table \
	|| { echo "build failed"; exit 1; }

out=$(./obj_dir/tb_lookup_table)
echo "$out"
echo "$out" | grep -q "Test completed successfully" && exit 0 || exit 1
